// ==== Bender.yml ====
package:
  name: alu_coprocessor

sources:
  - rtl/aluPkg.sv
  - rtl/barrelShifter.sv
  - rtl/claAdder.sv
  - rtl/alu.sv
  - rtl/aluWbRegs.sv
  - rtl/aluTop.sv
  - target: test
    files:
      - tests/aluTb.sv

// ==== filelist.f ====
rtl/aluPkg.sv
rtl/barrelShifter.sv
rtl/claAdder.sv
rtl/alu.sv
rtl/aluWbRegs.sv
rtl/aluTop.sv
tests/aluTb.sv

// ==== rtl/alu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU
// Operand inversion, shifts and rotates,
// add, logic ops, SLBI, bit reversal,
// result select and flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module alu #(
	parameter int dataWidth = 16
) (
	input  logic [dataWidth-1:0] inA,
	input  logic [dataWidth-1:0] inB,
	input  aluPkg::aluCtrl       ctrl,
	output logic [dataWidth-1:0] result,
	output aluPkg::aluFlags      flags
);

	import aluPkg::*;

	localparam int shWidth   = $clog2(dataWidth);
	localparam int halfWidth = dataWidth / 2;

	logic [dataWidth-1:0] useA;
	logic [dataWidth-1:0] useB;
	logic [dataWidth-1:0] shOut;
	logic [dataWidth-1:0] addSum;
	logic [dataWidth-1:0] slbiOut;
	logic [dataWidth-1:0] btrOut;
	logic [dataWidth-1:0] logicOut;
	logic [dataWidth-1:0] baseOut;
	logic [dataWidth-1:0] addedOut;
	logic                 addCout;
	logic                 addOfl;
	logic                 isRrl;

	// Optional inversion ahead of every op
	assign useA = ctrl.invA ? ~inA : inA;
	assign useB = ctrl.invB ? ~inB : inB;

	// rrl borrows the shifter in the right direction
	assign isRrl = (ctrl.oper == rrl);

	barrelShifter #(.dataWidth(dataWidth)) shift0 (
		.shIn    (useA),
		.shAmt   (useB[shWidth-1:0]),
		.mode    (ctrl.oper[1:0]),
		.rotRight(isRrl),
		.shOut   (shOut)
	);

	claAdder #(.dataWidth(dataWidth)) adder0 (
		.a   (useA),
		.b   (useB),
		.cin (ctrl.cin),
		.sign(ctrl.sign),
		.sum (addSum),
		.cout(addCout),
		.ofl (addOfl)
	);

	// SLBI: low half moves to the top
	assign slbiOut = useA << halfWidth;
	// Bit reversal
	assign btrOut  = {<<{useA}};

	// Add / and / or / xor on the low two bits
	always_comb begin
		case (ctrl.oper[1:0])
			2'b00:   logicOut = addSum;
			2'b01:   logicOut = useA & useB;
			2'b10:   logicOut = useA | useB;
			default: logicOut = useA ^ useB;
		endcase
	end

	// Bit 2 picks arithmetic/logic over shifts
	assign baseOut = ctrl.oper[2] ? logicOut : shOut;

	// Added ops; 1011 and up give zero
	always_comb begin
		case (ctrl.oper[2:0])
			3'b000:  addedOut = slbiOut;
			3'b001:  addedOut = btrOut;
			3'b010:  addedOut = shOut;
			default: addedOut = '0;
		endcase
	end

	assign result = ctrl.oper[3] ? addedOut : baseOut;

	// Adder flags are reported for every op
	assign flags.zero     = (result == '0);
	assign flags.ofl      = addOfl;
	assign flags.cout     = addCout;
	assign flags.signFlag = result[dataWidth-1];

endmodule

// ==== rtl/aluPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU coprocessor shared definitions
// Operation codes, control and flag words,
// Wishbone request/response and register map
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package aluPkg;

	// Bus geometry
	localparam int busWidth = 32;
	localparam int adrWidth = 3;

	// ALU operation codes, 1011 to 1111 unused
	typedef enum logic [3:0] {
		rll   = 4'b0000,
		sll   = 4'b0001,
		sra   = 4'b0010,
		srl   = 4'b0011,
		add   = 4'b0100,
		andOp = 4'b0101,
		orOp  = 4'b0110,
		xorOp = 4'b0111,
		slbi  = 4'b1000,
		btr   = 4'b1001,
		rrl   = 4'b1010
	} aluOp;

	// Low byte of the control register
	typedef struct packed {
		aluOp oper;
		logic invA;
		logic invB;
		logic sign;
		logic cin;
	} aluCtrl;

	// Low nibble of the flags register
	typedef struct packed {
		logic zero;
		logic ofl;
		logic cout;
		logic signFlag;
	} aluFlags;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [adrWidth-1:0] adr;
		logic [busWidth-1:0] dat;
	} wbReq;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic [busWidth-1:0] dat;
		logic                ack;
	} wbRsp;

	// Word addresses
	localparam logic [adrWidth-1:0] regOpA    = 3'd0;
	localparam logic [adrWidth-1:0] regOpB    = 3'd1;
	localparam logic [adrWidth-1:0] regCtrl   = 3'd2;
	localparam logic [adrWidth-1:0] regResult = 3'd3;
	localparam logic [adrWidth-1:0] regFlags  = 3'd4;

endpackage

// ==== rtl/aluTop.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU coprocessor top
// Wishbone register slave feeding the ALU
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module aluTop #(
	parameter int dataWidth = 16
) (
	input  logic         clk,
	input  logic         rst,
	input  aluPkg::wbReq bus,
	output aluPkg::wbRsp rsp
);

	import aluPkg::*;

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] result;
	aluCtrl               ctrl;
	aluFlags              flags;

	// Bus slave and operand/result registers
	aluWbRegs #(.dataWidth(dataWidth)) regs0 (
		.clk   (clk),
		.rst   (rst),
		.bus   (bus),
		.rsp   (rsp),
		.opA   (opA),
		.opB   (opB),
		.ctrl  (ctrl),
		.result(result),
		.flags (flags)
	);

	// Combinational datapath
	alu #(.dataWidth(dataWidth)) alu0 (
		.inA   (opA),
		.inB   (opB),
		.ctrl  (ctrl),
		.result(result),
		.flags (flags)
	);

endmodule

// ==== rtl/aluWbRegs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone register slave
// Operand, control, result and flag regs;
// a control write launches one operation
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module aluWbRegs #(
	parameter int dataWidth = 16
) (
	input  logic                 clk,
	input  logic                 rst,
	input  aluPkg::wbReq         bus,
	output aluPkg::wbRsp         rsp,
	output logic [dataWidth-1:0] opA,
	output logic [dataWidth-1:0] opB,
	output aluPkg::aluCtrl       ctrl,
	input  logic [dataWidth-1:0] result,
	input  aluPkg::aluFlags      flags
);

	import aluPkg::*;

	logic                 ackQ;
	logic [busWidth-1:0]  datQ;
	logic [busWidth-1:0]  rdData;
	logic [dataWidth-1:0] resultQ;
	aluFlags              flagsQ;
	logic                 launch;
	logic                 reqValid;
	logic                 wrReq;
	logic                 rdReq;

	// Request taken only while no ack is out,
	// so a held stb counts as a fresh request
	assign reqValid = bus.cyc & bus.stb & ~ackQ;
	assign wrReq    = reqValid & bus.we;
	assign rdReq    = reqValid & ~bus.we;

	// Read mux, zero-extended
	always_comb begin
		case (bus.adr)
			regOpA:    rdData = busWidth'(opA);
			regOpB:    rdData = busWidth'(opB);
			regCtrl:   rdData = busWidth'(ctrl);
			regResult: rdData = busWidth'(resultQ);
			regFlags:  rdData = busWidth'(flagsQ);
			// Unmapped reads return zero
			default:   rdData = '0;
		endcase
	end

	// Bus side: ack, read data, register writes
	always_ff @(posedge clk) begin
		if (rst) begin
			ackQ   <= 1'b0;
			datQ   <= '0;
			opA    <= '0;
			opB    <= '0;
			ctrl   <= '0;
			launch <= 1'b0;
		end else begin
			ackQ   <= reqValid;
			launch <= wrReq && (bus.adr == regCtrl);
			if (rdReq) begin
				datQ <= rdData;
			end
			if (wrReq) begin
				// Read-only and unmapped writes fall through
				case (bus.adr)
					regOpA:  opA  <= bus.dat[dataWidth-1:0];
					regOpB:  opB  <= bus.dat[dataWidth-1:0];
					regCtrl: ctrl <= aluCtrl'(bus.dat[$bits(aluCtrl)-1:0]);
					default: ;
				endcase
			end
		end
	end

	// Capture ALU outputs one edge after the control write
	always_ff @(posedge clk) begin
		if (rst) begin
			resultQ <= '0;
			flagsQ  <= '0;
		end else if (launch) begin
			resultQ <= result;
			flagsQ  <= flags;
		end
	end

	assign rsp.ack = ackQ;
	assign rsp.dat = datQ;

	// One-cycle ack
	ackSingle: assert property (@(posedge clk) disable iff (rst) rsp.ack |=> !rsp.ack)
		else $error("aluWbRegs: ack held for two edges");

	// Ack only after a sampled request
	ackAfterReq: assert property (@(posedge clk) disable iff (rst)
		rsp.ack |-> $past(bus.cyc && bus.stb))
		else $error("aluWbRegs: ack without a request");

endmodule

// ==== rtl/barrelShifter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Barrel shifter
// Rotate left/right, logical shifts and
// arithmetic right shift by a variable amount
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module barrelShifter #(
	parameter int dataWidth = 16
) (
	input  logic [dataWidth-1:0]         shIn,
	input  logic [$clog2(dataWidth)-1:0] shAmt,
	input  logic [1:0]                   mode,
	input  logic                         rotRight,
	output logic [dataWidth-1:0]         shOut
);

	localparam int numStages = $clog2(dataWidth);

	logic                 dirRight;
	logic                 rotate;
	logic                 fillBit;
	logic [dataWidth-1:0] revIn;
	logic [dataWidth-1:0] revOut;
	logic [dataWidth-1:0] stage [0:numStages];

	// Mode 00 rll, 01 sll, 10 sra, 11 srl
	assign dirRight = rotRight | mode[1];
	assign rotate   = rotRight | (mode == 2'b00);
	// Sign fill only for sra
	assign fillBit  = ~rotRight & (mode == 2'b10) & shIn[dataWidth-1];

	// Right moves run through the left network on mirrored data
	assign revIn    = {<<{shIn}};
	assign stage[0] = dirRight ? revIn : shIn;

	// Power-of-two steps, one per shAmt bit
	for (genvar k = 0; k < numStages; k++) begin : stg
		localparam int step = 2 ** k;
		logic [step-1:0] lowBits;

		// Wrapped bits on rotate, fill otherwise
		assign lowBits = rotate ? stage[k][dataWidth-1 -: step] : {step{fillBit}};
		assign stage[k+1] = shAmt[k] ? {stage[k][dataWidth-1-step:0], lowBits} : stage[k];
	end

	// Mirror back for right moves
	assign revOut = {<<{stage[numStages]}};
	assign shOut  = dirRight ? revOut : stage[numStages];

endmodule

// ==== rtl/claAdder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Carry-lookahead adder
// Four-bit lookahead groups under a group
// carry level; signed or unsigned overflow
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module claAdder #(
	parameter int dataWidth = 16
) (
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  logic                 cin,
	input  logic                 sign,
	output logic [dataWidth-1:0] sum,
	output logic                 cout,
	output logic                 ofl
);

	localparam int numGroups = dataWidth / 4;

	logic [dataWidth-1:0] gen;
	logic [dataWidth-1:0] prop;
	logic [dataWidth-1:0] carry;
	logic [numGroups-1:0] grpGen;
	logic [numGroups-1:0] grpProp;
	logic [numGroups:0]   grpCarry;
	logic [dataWidth:0]   refSum;

	// Bit generate and propagate
	assign gen  = a & b;
	assign prop = a ^ b;

	assign grpCarry[0] = cin;

	for (genvar k = 0; k < numGroups; k++) begin : grp
		localparam int base = 4 * k;

		// Carries inside the group, all from the group carry in
		assign carry[base]   = grpCarry[k];
		assign carry[base+1] = gen[base] | (prop[base] & grpCarry[k]);
		assign carry[base+2] = gen[base+1] | (prop[base+1] & gen[base]) |
			(&prop[base+1:base] & grpCarry[k]);
		assign carry[base+3] = gen[base+2] | (prop[base+2] & gen[base+1]) |
			(&prop[base+2:base+1] & gen[base]) | (&prop[base+2:base] & grpCarry[k]);

		// Group terms for the upper level
		assign grpGen[k] = gen[base+3] | (prop[base+3] & gen[base+2]) |
			(&prop[base+3:base+2] & gen[base+1]) | (&prop[base+3:base+1] & gen[base]);
		assign grpProp[k] = &prop[base+3:base];
		assign grpCarry[k+1] = grpGen[k] | (grpProp[k] & grpCarry[k]);
	end

	assign sum  = prop ^ carry;
	assign cout = grpCarry[numGroups];

	// Signed: like-signed operands giving a sum of the other sign
	assign ofl = sign ? ((a[dataWidth-1] == b[dataWidth-1]) &&
		(sum[dataWidth-1] != a[dataWidth-1])) : cout;

	// Lookahead tree must agree with a plain add once inputs are known
	assign refSum = {1'b0, a} + {1'b0, b} + cin;
	always_comb begin
		assert final ($isunknown({a, b, cin}) || ({cout, sum} == refSum))
		else $error("claAdder: lookahead sum %h differs from %h", {cout, sum}, refSum);
	end

endmodule

// ==== tests/aluTb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU coprocessor testbench
// Directed Wishbone tests checked against
// a reference model of the ALU rules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module aluTb;

	import aluPkg::*;

	localparam int dw       = 16;
	localparam int ackLimit = 20;

	logic        clk;
	logic        rst;
	wbReq        bus;
	wbRsp        rsp;
	logic [31:0] seed;
	logic [31:0] lastResult;
	int          checks;
	int          valueErrors;
	int          otherErrors;

	aluTop #(.dataWidth(dw)) dut0 (
		.clk(clk),
		.rst(rst),
		.bus(bus),
		.rsp(rsp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// LCG, upper half is better mixed
	function automatic logic [15:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	// Control word from opcode and {invA, invB, sign, cin}
	function automatic aluCtrl makeCtrl(input logic [3:0] op, input logic [3:0] mods);
		aluCtrl c;
		c.oper = aluOp'(op);
		{c.invA, c.invB, c.sign, c.cin} = mods;
		return c;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			valueErrors++;
			$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// One ack, then release the bus and see ack drop
	task automatic waitAck(output logic [31:0] dat);
		int cnt;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!rsp.ack && cnt < ackLimit);
		checks++;
		assert (rsp.ack)
		else begin
			otherErrors++;
			$display("no ack within %0d cycles at %0t", ackLimit, $time);
		end
		dat = rsp.dat;
		@(posedge clk);
		bus <= '0;
		@(negedge clk);
		checks++;
		assert (!rsp.ack)
		else begin
			otherErrors++;
			$display("ack stayed high for a second cycle at %0t", $time);
		end
	endtask

	task automatic busWrite(input logic [adrWidth-1:0] addr, input logic [31:0] wdat);
		logic [31:0] unused;
		@(posedge clk);
		bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: wdat};
		waitAck(unused);
	endtask

	task automatic busRead(input logic [adrWidth-1:0] addr, output logic [31:0] rdat);
		@(posedge clk);
		bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 32'h0};
		waitAck(rdat);
	endtask

	// Reference ALU built from the operation rules
	task automatic refAlu(input logic [15:0] a, input logic [15:0] b, input aluCtrl c,
		output logic [15:0] res, output aluFlags f);
		logic [15:0] ua;
		logic [15:0] ub;
		logic [31:0] dbl;
		logic [16:0] wide;
		int          amt;
		ua   = c.invA ? ~a : a;
		ub   = c.invB ? ~b : b;
		amt  = ub[3:0];
		dbl  = {ua, ua};
		wide = {1'b0, ua} + {1'b0, ub} + c.cin;
		case (c.oper)
			rll:     res = dbl[31-amt -: 16];
			sll:     res = ua << amt;
			sra:     res = $signed(ua) >>> amt;
			srl:     res = ua >> amt;
			add:     res = wide[15:0];
			andOp:   res = ua & ub;
			orOp:    res = ua | ub;
			xorOp:   res = ua ^ ub;
			slbi:    res = ua << 8;
			btr:     for (int i = 0; i < 16; i++) res[i] = ua[15-i];
			rrl:     res = dbl[15+amt -: 16];
			default: res = '0;
		endcase
		f.zero     = (res == 16'h0);
		f.signFlag = res[15];
		f.cout     = wide[16];
		// Signed overflow when like signs give the other sign
		f.ofl      = c.sign ? (ua[15] == ub[15] && wide[15] != ua[15]) : wide[16];
	endtask

	task automatic runOp(input logic [15:0] a, input logic [15:0] b, input aluCtrl c);
		logic [15:0] expRes;
		aluFlags     expFlags;
		logic [31:0] got;
		refAlu(a, b, c, expRes, expFlags);
		busWrite(regOpA, {16'h0, a});
		busWrite(regOpB, {16'h0, b});
		busWrite(regCtrl, {24'h0, c});
		busRead(regResult, got);
		checkValue("result", got, {16'h0, expRes});
		lastResult = got;
		busRead(regFlags, got);
		checkValue("flags", got, {28'h0, expFlags});
	endtask

	// Registers clear on reset
	task automatic checkReset();
		logic [31:0] got;
		busRead(regResult, got);
		checkValue("result after reset", got, 32'h0);
		busRead(regFlags, got);
		checkValue("flags after reset", got, 32'h0);
	endtask

	// rll, sll, sra, srl and rrl over every amount
	task automatic checkShifts();
		logic [3:0]  ops [5];
		logic [15:0] rb;
		ops = '{4'b0000, 4'b0001, 4'b0010, 4'b0011, 4'b1010};
		foreach (ops[i]) begin
			for (int amt = 0; amt < 16; amt++) begin
				rb      = nextRand();
				rb[3:0] = amt[3:0];
				runOp(nextRand(), rb, makeCtrl(ops[i], {amt[0], 3'b000}));
			end
		end
	endtask

	task automatic checkAdds();
		for (int m = 0; m < 16; m++) begin
			for (int n = 0; n < 4; n++) begin
				runOp(nextRand(), nextRand(), makeCtrl(4'b0100, m[3:0]));
			end
		end
		// Edge values, signed and unsigned
		runOp(16'h7fff, 16'h0001, makeCtrl(4'b0100, 4'b0010));
		runOp(16'h7fff, 16'h0001, makeCtrl(4'b0100, 4'b0000));
		runOp(16'hffff, 16'h0001, makeCtrl(4'b0100, 4'b0000));
		runOp(16'hffff, 16'h0001, makeCtrl(4'b0100, 4'b0010));
		runOp(16'h8000, 16'h8000, makeCtrl(4'b0100, 4'b0010));
		// 5 - 7 through invB with cin
		runOp(16'h0005, 16'h0007, makeCtrl(4'b0100, 4'b0111));
	endtask

	// Logic ops, slbi, btr and undefined codes
	task automatic checkLogic();
		logic [3:0] ops [5];
		ops = '{4'b0101, 4'b0110, 4'b0111, 4'b1000, 4'b1001};
		foreach (ops[i]) begin
			for (int m = 0; m < 4; m++) begin
				runOp(nextRand(), nextRand(), makeCtrl(ops[i], {m[1:0], 2'b00}));
			end
		end
		for (int op = 11; op < 16; op++) begin
			runOp(nextRand(), nextRand(), makeCtrl(op[3:0], 4'b0000));
			checkValue("undefined op result", lastResult, 32'h0);
		end
	endtask

	// Flags follow result; operand writes alone launch nothing
	task automatic checkHold();
		logic [31:0] got;
		runOp(16'h1234, 16'h1234, makeCtrl(4'b0111, 4'b0000));
		runOp(16'h8000, 16'h0001, makeCtrl(4'b0110, 4'b0000));
		busWrite(regOpA, 32'h0000_0f0f);
		busWrite(regOpB, 32'h0000_00ff);
		busRead(regResult, got);
		// Still 8000 OR 0001 from the last launch
		checkValue("result after operand writes", got, 32'h0000_8001);
		// Same control again reruns on new operands
		busWrite(regCtrl, {24'h0, makeCtrl(4'b0110, 4'b0000)});
		busRead(regResult, got);
		checkValue("result after control rewrite", got, 32'h0000_0fff);
	endtask

	task automatic checkUnmapped();
		logic [31:0] got;
		busWrite(regResult, 32'h0000_dead);
		busWrite(regFlags, 32'h0000_000f);
		for (int adr = 5; adr < 8; adr++) begin
			busWrite(adr[2:0], 32'hffff_ffff);
		end
		// 0f0f OR 00ff, no carry out of 0f0f + 00ff, so all flags clear
		busRead(regResult, got);
		checkValue("result after ignored writes", got, 32'h0000_0fff);
		busRead(regFlags, got);
		checkValue("flags after ignored writes", got, 32'h0);
		busRead(regOpA, got);
		checkValue("opA after ignored writes", got, 32'h0000_0f0f);
		for (int adr = 5; adr < 8; adr++) begin
			busRead(adr[2:0], got);
			checkValue("unmapped read", got, 32'h0);
		end
	endtask

	initial begin
		seed        = 32'h3a5d4d90;
		lastResult  = '0;
		checks      = 0;
		valueErrors = 0;
		otherErrors = 0;
		bus         = '0;
		rst         = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		checkReset();
		checkShifts();
		checkAdds();
		checkLogic();
		checkHold();
		checkUnmapped();
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
